// ==== hw/mem_map_pkg.sv ====
//--------------------
// Bus widths shared by the memory window subsystem
// Addresses are byte addresses; data moves as whole 32-bit words
//--------------------
`default_nettype none

package mem_map_pkg;

    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned DATA_W     = 32;
    localparam int unsigned WORD_BYTES = DATA_W / 8;
    // Low address bits that select a byte inside a word
    localparam int unsigned BYTE_OFS_W = $clog2(WORD_BYTES);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [WORD_BYTES-1:0] strb_t;

    // Byte-wise merge of a write into an existing word
    function automatic data_t strb_merge(data_t old_word, data_t new_word, strb_t strb);
        data_t res;
        res = old_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== hw/csr_pkg.sv ====
//--------------------
// CSR window layout, offsets relative to the CSR base
// Only word-aligned offsets listed here are mapped
//--------------------
`default_nettype none

package csr_pkg;

    localparam int unsigned CSR_WINDOW_BYTES = 256;
    localparam int unsigned CSR_OFS_W        = $clog2(CSR_WINDOW_BYTES);

    typedef logic [CSR_OFS_W-1:0] csr_ofs_t;

    localparam csr_ofs_t CSR_ID_OFS       = 8'h00;
    localparam csr_ofs_t CSR_GPIO_OUT_OFS = 8'h04;
    localparam csr_ofs_t CSR_GPIO_IN_OFS  = 8'h08;
    // First of a contiguous run of scratch words
    localparam csr_ofs_t CSR_SCRATCH0_OFS = 8'h10;
    localparam int unsigned CSR_SCRATCH_WORDS = 4;

    localparam mem_map_pkg::data_t CSR_ID_VALUE = 32'h4D57_0001;

endpackage

`default_nettype wire

// ==== hw/mem_req_if.sv ====
//--------------------
// Single-beat request, no handshake
// A request exists in every cycle with valid high
//--------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

    logic               valid;
    logic               write;
    mem_map_pkg::addr_t addr;
    mem_map_pkg::data_t wdata;
    mem_map_pkg::strb_t strb;

    modport src (
        output valid, write, addr, wdata, strb
    );

    modport dst (
        input valid, write, addr, wdata, strb
    );

endinterface

`default_nettype wire

// ==== hw/addr_decode.sv ====
//--------------------
// Bases must be aligned to their window size
// Windows must not overlap; SRAM wins if they do
//--------------------
`timescale 1ns/1ps
`default_nettype none

module addr_decode #(
    parameter int unsigned        SRAM_WORDS = 256,
    parameter mem_map_pkg::addr_t SRAM_BASE  = 32'h2000_0000,
    parameter mem_map_pkg::addr_t CSR_BASE   = 32'h3000_0000
) (
    input  wire logic clk,
    input  wire logic arst_n,
    mem_req_if.dst    req_in,
    mem_req_if.src    sram_req,
    mem_req_if.src    csr_req,
    output logic      miss
);

    localparam int unsigned ADDR_W  = mem_map_pkg::ADDR_W;
    localparam int unsigned SRAM_AW = $clog2(SRAM_WORDS * mem_map_pkg::WORD_BYTES);
    localparam int unsigned CSR_AW  = $clog2(csr_pkg::CSR_WINDOW_BYTES);

    localparam mem_map_pkg::addr_t SRAM_MASK = mem_map_pkg::addr_t'((1 << SRAM_AW) - 1);
    localparam mem_map_pkg::addr_t CSR_MASK  = mem_map_pkg::addr_t'((1 << CSR_AW) - 1);

    logic sram_hit;
    logic csr_hit;

    // Upper address bits select the window
    assign sram_hit = req_in.addr[ADDR_W-1:SRAM_AW] == SRAM_BASE[ADDR_W-1:SRAM_AW];
    assign csr_hit  = !sram_hit &&
                      (req_in.addr[ADDR_W-1:CSR_AW] == CSR_BASE[ADDR_W-1:CSR_AW]);

    assign sram_req.valid = req_in.valid && sram_hit;
    assign sram_req.write = req_in.write;
    assign sram_req.addr  = req_in.addr & SRAM_MASK;
    assign sram_req.wdata = req_in.wdata;
    assign sram_req.strb  = req_in.strb;

    assign csr_req.valid = req_in.valid && csr_hit;
    assign csr_req.write = req_in.write;
    assign csr_req.addr  = req_in.addr & CSR_MASK;
    assign csr_req.wdata = req_in.wdata;
    assign csr_req.strb  = req_in.strb;

    // Delayed to line up with the target response registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            miss <= 1'b0;
        end else begin
            miss <= req_in.valid && !sram_hit && !csr_hit;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sram_target.sv ====
//--------------------
// SRAM_WORDS must be a power of two, at least 2
// Contents are undefined after power-up
//--------------------
`timescale 1ns/1ps
`default_nettype none

module sram_target #(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  wire logic          clk,
    input  wire logic          arst_n,
    mem_req_if.dst             req,
    output logic               rsp_valid,
    output mem_map_pkg::data_t rsp_rdata,
    output logic               rsp_err
);

    localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

    mem_map_pkg::data_t mem [SRAM_WORDS];
    logic [IDX_W-1:0]   idx;

    // Word index, byte lanes dropped
    assign idx = req.addr[mem_map_pkg::BYTE_OFS_W +: IDX_W];

    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            mem[idx] <= mem_map_pkg::strb_merge(mem[idx], req.wdata, req.strb);
        end
    end

    // Read data lands with the response; writes answer with zero
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_rdata <= req.write ? '0 : mem[idx];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.valid;
        end
    end

    // Every offset in the window maps to a word
    assign rsp_err = 1'b0;

endmodule

`default_nettype wire

// ==== hw/csr_target.sv ====
//--------------------
// Unmapped or unaligned offsets and writes to ID or GPIO_IN
// return an error and change nothing
//--------------------
`timescale 1ns/1ps
`default_nettype none

module csr_target (
    input  wire logic               clk,
    input  wire logic               arst_n,
    mem_req_if.dst                  req,
    input  wire mem_map_pkg::data_t gpio_in,
    output mem_map_pkg::data_t      gpio_out,
    output logic                    rsp_valid,
    output mem_map_pkg::data_t      rsp_rdata,
    output logic                    rsp_err
);

    localparam int unsigned SCR_IDX_W = $clog2(csr_pkg::CSR_SCRATCH_WORDS);
    localparam csr_pkg::csr_ofs_t SCR_SPAN =
        csr_pkg::csr_ofs_t'(csr_pkg::CSR_SCRATCH_WORDS * mem_map_pkg::WORD_BYTES);

    mem_map_pkg::data_t   scratch [csr_pkg::CSR_SCRATCH_WORDS];
    csr_pkg::csr_ofs_t    ofs;
    csr_pkg::csr_ofs_t    scr_rel;
    logic [SCR_IDX_W-1:0] scr_idx;
    logic                 scr_hit;
    mem_map_pkg::data_t   rd_word;
    logic                 acc_err;
    logic                 gpio_wr;
    logic                 scr_wr;

    assign ofs     = req.addr[csr_pkg::CSR_OFS_W-1:0];
    // Below the scratch base this wraps high and misses the span
    assign scr_rel = ofs - csr_pkg::CSR_SCRATCH0_OFS;
    assign scr_idx = scr_rel[mem_map_pkg::BYTE_OFS_W +: SCR_IDX_W];
    assign scr_hit = (scr_rel < SCR_SPAN) && (scr_rel[mem_map_pkg::BYTE_OFS_W-1:0] == '0);

    always_comb begin
        rd_word = '0;
        acc_err = 1'b0;
        gpio_wr = 1'b0;
        scr_wr  = 1'b0;
        case (ofs)
            csr_pkg::CSR_ID_OFS: begin
                rd_word = csr_pkg::CSR_ID_VALUE;
                acc_err = req.write;
            end
            csr_pkg::CSR_GPIO_OUT_OFS: begin
                rd_word = gpio_out;
                gpio_wr = req.write;
            end
            csr_pkg::CSR_GPIO_IN_OFS: begin
                rd_word = gpio_in;
                acc_err = req.write;
            end
            default: begin
                if (scr_hit) begin
                    rd_word = scratch[scr_idx];
                    scr_wr  = req.write;
                end else begin
                    acc_err = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out  <= '0;
            scratch   <= '{default: '0};
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            rsp_valid <= req.valid;
            rsp_err   <= req.valid && acc_err;
            if (req.valid && gpio_wr) begin
                gpio_out <= mem_map_pkg::strb_merge(gpio_out, req.wdata, req.strb);
            end
            if (req.valid && scr_wr) begin
                scratch[scr_idx] <= mem_map_pkg::strb_merge(scratch[scr_idx], req.wdata,
                                                            req.strb);
            end
        end
    end

    // Zero for writes and errors, else the word seen at request time
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_rdata <= (req.write || acc_err) ? '0 : rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rsp_merge.sv ====
//--------------------
// Expects at most one active source per cycle
//--------------------
`timescale 1ns/1ps
`default_nettype none

module rsp_merge (
    input  wire logic               sram_valid,
    input  wire mem_map_pkg::data_t sram_rdata,
    input  wire logic               sram_err,
    input  wire logic               csr_valid,
    input  wire mem_map_pkg::data_t csr_rdata,
    input  wire logic               csr_err,
    input  wire logic               miss,
    output logic                    rsp_valid,
    output mem_map_pkg::data_t      rsp_rdata,
    output logic                    rsp_err
);

    always_comb begin
        rsp_valid = sram_valid || csr_valid || miss;
        rsp_rdata = '0;
        rsp_err   = 1'b0;
        if (sram_valid) begin
            rsp_rdata = sram_rdata;
            rsp_err   = sram_err;
        end else if (csr_valid) begin
            rsp_rdata = csr_rdata;
            rsp_err   = csr_err;
        end else if (miss) begin
            // Unmapped address, data stays zero
            rsp_err = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_window_top.sv ====
//--------------------
// Fixed one-cycle response, no back-pressure
// Consumer must take each response when it appears
//--------------------
`timescale 1ns/1ps
`default_nettype none

module mem_window_top #(
    parameter int unsigned        SRAM_WORDS = 256,
    parameter mem_map_pkg::addr_t SRAM_BASE  = 32'h2000_0000,
    parameter mem_map_pkg::addr_t CSR_BASE   = 32'h3000_0000
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               req_valid,
    input  wire logic               req_write,
    input  wire mem_map_pkg::addr_t req_addr,
    input  wire mem_map_pkg::data_t req_wdata,
    input  wire mem_map_pkg::strb_t req_strb,
    input  wire mem_map_pkg::data_t gpio_in,
    output logic                    rsp_valid,
    output mem_map_pkg::data_t      rsp_rdata,
    output logic                    rsp_err,
    output mem_map_pkg::data_t      gpio_out
);

    mem_req_if req_in ();
    mem_req_if sram_req ();
    mem_req_if csr_req ();

    logic               miss;
    logic               sram_valid;
    mem_map_pkg::data_t sram_rdata;
    logic               sram_err;
    logic               csr_valid;
    mem_map_pkg::data_t csr_rdata;
    logic               csr_err;

    assign req_in.valid = req_valid;
    assign req_in.write = req_write;
    assign req_in.addr  = req_addr;
    assign req_in.wdata = req_wdata;
    assign req_in.strb  = req_strb;

    addr_decode #(
        .SRAM_WORDS (SRAM_WORDS),
        .SRAM_BASE  (SRAM_BASE),
        .CSR_BASE   (CSR_BASE)
    ) u_addr_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .req_in   (req_in.dst),
        .sram_req (sram_req.src),
        .csr_req  (csr_req.src),
        .miss     (miss)
    );

    sram_target #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram_target (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (sram_req.dst),
        .rsp_valid (sram_valid),
        .rsp_rdata (sram_rdata),
        .rsp_err   (sram_err)
    );

    csr_target u_csr_target (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (csr_req.dst),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .rsp_valid (csr_valid),
        .rsp_rdata (csr_rdata),
        .rsp_err   (csr_err)
    );

    rsp_merge u_rsp_merge (
        .sram_valid (sram_valid),
        .sram_rdata (sram_rdata),
        .sram_err   (sram_err),
        .csr_valid  (csr_valid),
        .csr_rdata  (csr_rdata),
        .csr_err    (csr_err),
        .miss       (miss),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err)
    );

endmodule

`default_nettype wire

// ==== verif/mem_window_tb.sv ====
//--------------------
// Run from the project root, reads verif/mem_window_golden.txt
// Golden addresses assume the bases and SRAM depth set below
// Golden columns: group start, op, addr, wdata, strb, gpio_in, rdata, err
//--------------------
`timescale 1ns/1ps
`default_nettype none

module mem_window_tb;

    localparam int unsigned        SRAM_WORDS    = 256;
    localparam mem_map_pkg::addr_t SRAM_BASE     = 32'h2000_0000;
    localparam mem_map_pkg::addr_t CSR_BASE      = 32'h3000_0000;
    localparam mem_map_pkg::addr_t GPIO_OUT_ADDR = CSR_BASE + 32'h4;
    localparam int                 MAX_LINES     = 64;

    logic               clk;
    logic               arst_n;
    logic               req_valid;
    logic               req_write;
    mem_map_pkg::addr_t req_addr;
    mem_map_pkg::data_t req_wdata;
    mem_map_pkg::strb_t req_strb;
    mem_map_pkg::data_t gpio_in;
    logic               rsp_valid;
    mem_map_pkg::data_t rsp_rdata;
    logic               rsp_err;
    mem_map_pkg::data_t gpio_out;

    // Golden table, one entry per request line
    logic               g_grp   [MAX_LINES];
    logic               g_op    [MAX_LINES];
    mem_map_pkg::addr_t g_addr  [MAX_LINES];
    mem_map_pkg::data_t g_wdata [MAX_LINES];
    mem_map_pkg::strb_t g_strb  [MAX_LINES];
    mem_map_pkg::data_t g_gpin  [MAX_LINES];
    mem_map_pkg::data_t g_rdata [MAX_LINES];
    logic               g_err   [MAX_LINES];

    int          n_lines;
    bit          loaded;
    int          errors;
    // Line index driven one and two edges ago, -1 when idle
    int          pend0;
    int          pend1;

    always #10 clk = ~clk;

    mem_window_top #(
        .SRAM_WORDS (SRAM_WORDS),
        .SRAM_BASE  (SRAM_BASE),
        .CSR_BASE   (CSR_BASE)
    ) dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_strb  (req_strb),
        .gpio_in   (gpio_in),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .gpio_out  (gpio_out)
    );

    task automatic load_golden();
        int          fd;
        int          n;
        logic [31:0] f_grp, f_op, f_addr, f_wdata, f_strb, f_gpin, f_rdata, f_err;
        n_lines = 0;
        fd = $fopen("verif/mem_window_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/mem_window_golden.txt");
        end else begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h\n", f_grp, f_op, f_addr, f_wdata,
                        f_strb, f_gpin, f_rdata, f_err);
            while (n == 8 && n_lines < MAX_LINES) begin
                g_grp[n_lines]   = f_grp[0];
                g_op[n_lines]    = f_op[0];
                g_addr[n_lines]  = f_addr;
                g_wdata[n_lines] = f_wdata;
                g_strb[n_lines]  = f_strb[3:0];
                g_gpin[n_lines]  = f_gpin;
                g_rdata[n_lines] = f_rdata;
                g_err[n_lines]   = f_err[0];
                n_lines++;
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h\n", f_grp, f_op, f_addr, f_wdata,
                            f_strb, f_gpin, f_rdata, f_err);
            end
            $fclose(fd);
        end
    endtask

    // Golden line of the next GPIO_OUT read, -1 if another write comes first
    function automatic int next_gpio_read(input int idx);
        for (int j = idx + 1; j < n_lines; j++) begin
            if (g_addr[j] == GPIO_OUT_ADDR && !g_err[j]) begin
                return g_op[j] ? -1 : j;
            end
        end
        return -1;
    endfunction

    // Response expected now for the request driven two edges back
    task automatic check_slot(input int idx);
        int nxt;
        if (idx < 0) begin
            assert (rsp_valid === 1'b0) else begin
                $display("Error at %t: response with no request outstanding", $time);
                errors++;
            end
        end else begin
            assert (rsp_valid === 1'b1) else begin
                $display("No response arrived for golden line %0d, expected at %t",
                         idx + 1, $time);
                errors++;
            end
            if (rsp_valid === 1'b1) begin
                assert (rsp_rdata === g_rdata[idx]) else begin
                    $display("Error at %t: line %0d rdata %h, expected %h",
                             $time, idx + 1, rsp_rdata, g_rdata[idx]);
                    errors++;
                end
                assert (rsp_err === g_err[idx]) else begin
                    $display("Error at %t: line %0d err %b, expected %b",
                             $time, idx + 1, rsp_err, g_err[idx]);
                    errors++;
                end
            end
            // Output wires follow the register a read of GPIO_OUT returns
            if (!g_op[idx] && !g_err[idx] && g_addr[idx] == GPIO_OUT_ADDR) begin
                assert (gpio_out === g_rdata[idx]) else begin
                    $display("Error at %t: line %0d gpio_out %h, expected %h",
                             $time, idx + 1, gpio_out, g_rdata[idx]);
                    errors++;
                end
            end
            // New GPIO_OUT value already on the wires in the response cycle
            if (g_op[idx] && !g_err[idx] && g_addr[idx] == GPIO_OUT_ADDR) begin
                nxt = next_gpio_read(idx);
                if (nxt >= 0) begin
                    assert (gpio_out === g_rdata[nxt]) else begin
                        $display("Error at %t: line %0d gpio_out %h after write, expected %h",
                                 $time, idx + 1, gpio_out, g_rdata[nxt]);
                        errors++;
                    end
                end
            end
        end
    endtask

    // One clock: check the due response, then drive a request or idle
    task automatic step(input int idx);
        @(posedge clk);
        check_slot(pend1);
        pend1 = pend0;
        pend0 = idx;
        if (idx >= 0) begin
            req_valid <= 1'b1;
            req_write <= g_op[idx];
            req_addr  <= g_addr[idx];
            req_wdata <= g_wdata[idx];
            req_strb  <= g_strb[idx];
            gpio_in   <= g_gpin[idx];
        end else begin
            req_valid <= 1'b0;
        end
    endtask

    task automatic run_requests();
        int gap;
        for (int i = 0; i < n_lines; i++) begin
            if (g_grp[i]) begin
                gap = $urandom % 3;
                repeat (gap) step(-1);
            end
            step(i);
        end
        // Two idle edges drain the pipeline
        step(-1);
        step(-1);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_strb  = '0;
        gpio_in   = '0;
        errors    = 0;
        pend0     = -1;
        pend1     = -1;
        void'($urandom(32));
        load_golden();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert (rsp_valid === 1'b0 && gpio_out === '0) else begin
            $display("Error at %t: rsp_valid %b gpio_out %h after reset", $time,
                     rsp_valid, gpio_out);
            errors++;
        end
        if (n_lines == 0) begin
            $display("No requests were loaded from the golden file");
            errors++;
        end else begin
            run_requests();
        end
        $display("Errors: %0d over %0d golden lines", errors, n_lines);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_lines * 4 + 50) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", n_lines * 4 + 50);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mem_window_golden.txt ====
1 1 20000000 11223344 f 00000000 00000000 0
0 1 200003fc a5a5a5a5 f 00000000 00000000 0
0 1 20000000 000000ee 1 00000000 00000000 0
0 1 20000000 bb000000 8 00000000 00000000 0
0 1 200003fc 00777700 6 00000000 00000000 0
0 0 20000000 00000000 0 00000000 bb2233ee 0
0 0 200003fc 00000000 0 00000000 a57777a5 0
1 0 30000000 00000000 0 00000000 4d570001 0
0 1 30000010 cafef00d f 00000000 00000000 0
0 1 30000010 00001234 3 00000000 00000000 0
0 0 30000010 00000000 0 00000000 cafe1234 0
0 1 3000001c 12345678 f 00000000 00000000 0
0 0 3000001c 00000000 0 00000000 12345678 0
0 1 30000004 0000ff00 2 00000000 00000000 0
0 0 30000004 00000000 0 00000000 0000ff00 0
0 0 30000008 00000000 0 5a5a0f0f 5a5a0f0f 0
1 1 30000000 ffffffff f 00000000 00000000 1
0 0 30000000 00000000 0 00000000 4d570001 0
0 1 30000008 ffffffff f 00000000 00000000 1
0 0 30000008 00000000 0 c3c3c3c3 c3c3c3c3 0
0 0 3000000c 00000000 0 00000000 00000000 1
0 1 30000020 ffffffff f 00000000 00000000 1
0 0 30000012 00000000 0 00000000 00000000 1
0 0 3000001c 00000000 0 00000000 12345678 0
1 0 40000000 00000000 0 00000000 00000000 1
0 1 20000400 ffffffff f 00000000 00000000 1
0 0 20000000 00000000 0 00000000 bb2233ee 0
1 1 20000100 01020304 f 00000000 00000000 0
0 0 30000014 00000000 0 00000000 00000000 0
0 0 50000000 00000000 0 00000000 00000000 1
0 0 20000100 00000000 0 00000000 01020304 0
0 0 30000000 00000000 0 00000000 4d570001 0
0 1 60000010 00000012 1 00000000 00000000 1
0 0 20000100 00000000 0 00000000 01020304 0
0 0 30000004 00000000 0 00000000 0000ff00 0

// ==== vlog.f ====
hw/mem_map_pkg.sv
hw/csr_pkg.sv
hw/mem_req_if.sv
hw/addr_decode.sv
hw/sram_target.sv
hw/csr_target.sv
hw/rsp_merge.sv
hw/mem_window_top.sv
verif/mem_window_tb.sv
